// File: bench/decodeStageTb.sv
// Self-checking testbench for decodeStage; needs concurrent assertion support, run ends at 4000 cycles
`timescale 1ns/1ps
`include "rvDecode_defs.svh"

module decodeStageTb
    import rvDecodePkg::*;
();

    typedef struct packed {
        logic    memWrite;
        logic    memRead;
        logic    regWrite;
        logic    memToReg;
        logic    aluSrc;
        aluOpT   aluOp;
        logic    pcSrc;
        funct3T  branchType;
        aluCtrlT aluControl;
        logic    illegal;
        wordT    imm;
    } expT;

    logic    clk = 1'b0;
    logic    rst;
    logic    stall;
    wordT    nextInstruction;
    wordT    pc;
    wordT    regValue1;
    wordT    regValue2;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT regDest;
    wordT    imm;
    wordT    pcOut;
    wordT    value1;
    wordT    value2;
    logic    memWrite;
    logic    memRead;
    logic    regWrite;
    logic    memToReg;
    logic    aluSrc;
    aluOpT   aluOp;
    logic    pcSrc;
    funct3T  branchType;
    aluCtrlT aluControl;
    logic    illegal;

    // Expected copy of the last unstalled input
    wordT expInstr;
    wordT expPc;
    wordT expValue1;
    wordT expValue2;
    expT  want;

    int errorCount = 0;
    int testCount = 0;
    int cycleCount = 0;

    decodeStage u_decodeStage (.*);

    always #4 clk = ~clk;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            expInstr  <= '0;
            expPc     <= '0;
            expValue1 <= '0;
            expValue2 <= '0;
        end
        else if (!stall)
        begin
            expInstr  <= nextInstruction;
            expPc     <= pc;
            expValue1 <= regValue1;
            expValue2 <= regValue2;
        end
    end

    // Bit 5 is the illegal flag, bits 4:0 the ALU code
    function automatic logic [5:0] refAlu(input wordT w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       isImm;
        logic [4:0] base;
        f3 = w[14:12];
        f7 = w[31:25];
        isImm = (w[6:0] == `OPC_OP_IMM);
        case (f3)
            3'd0:    base = `ALU_ADD;
            3'd1:    base = `ALU_SLL;
            3'd2:    base = `ALU_SLT;
            3'd3:    base = `ALU_SLTU;
            3'd4:    base = `ALU_XOR;
            3'd5:    base = `ALU_SRL;
            3'd6:    base = `ALU_OR;
            default: base = `ALU_AND;
        endcase
        // M codes are numbered in funct3 order from MUL
        if (!isImm && f7 == `F7_MULDIV)
            return {1'b0, `ALU_MUL + {2'b00, f3}};
        if (f7 == `F7_ALT && f3 == 3'd5)
            return {1'b0, `ALU_SRA};
        if (f7 == `F7_ALT && f3 == 3'd0 && !isImm)
            return {1'b0, `ALU_SUB};
        // Immediate forms carry immediate bits in funct7, except the shifts
        if (f7 == `F7_BASE || (isImm && f3 != 3'd1 && f3 != 3'd5))
            return {1'b0, base};
        return 6'b100000;
    endfunction

    function automatic wordT refImm(input wordT w, input immFmtT fmt);
        logic signed [11:0] i12;
        logic signed [11:0] s12;
        logic signed [12:0] b13;
        logic signed [20:0] j21;
        i12 = w[31:20];
        s12 = {w[31:25], w[11:7]};
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (fmt)
            fmtI:    return 32'(i12);
            fmtS:    return 32'(s12);
            fmtB:    return 32'(b13);
            fmtU:    return {w[31:12], 12'h000};
            fmtJ:    return 32'(j21);
            default: return '0;
        endcase
    endfunction

    function automatic expT refDecode(input wordT w);
        expT        e;
        immFmtT     fmt;
        logic [5:0] alu;
        logic [2:0] f3;
        e = '0;
        fmt = fmtNone;
        f3 = w[14:12];
        alu = refAlu(w);
        case (w[6:0])
            `OPC_LUI, `OPC_AUIPC:
            begin
                e.aluOp = (w[6:0] == `OPC_LUI) ? `AOP_LUI : `AOP_AUIPC;
                e.aluSrc = 1'b1;
                e.regWrite = 1'b1;
                e.aluControl = `ALU_ADD;
                fmt = fmtU;
            end
            `OPC_JAL, `OPC_JALR:
            begin
                e.aluOp = (w[6:0] == `OPC_JAL) ? `AOP_JAL : `AOP_JALR;
                e.regWrite = 1'b1;
                e.pcSrc = 1'b1;
                e.aluControl = `ALU_ADD;
                fmt = (w[6:0] == `OPC_JAL) ? fmtJ : fmtI;
                e.illegal = (w[6:0] == `OPC_JALR) && (f3 != 3'd0);
            end
            `OPC_BRANCH:
            begin
                e.aluOp = `AOP_BRANCH;
                e.pcSrc = 1'b1;
                e.aluControl = `ALU_SUB;
                e.branchType = f3;
                fmt = fmtB;
                e.illegal = (f3 == 3'd2) || (f3 == 3'd3);
            end
            `OPC_LOAD, `OPC_STORE:
            begin
                e.aluOp = `AOP_MEM;
                e.aluSrc = 1'b1;
                e.aluControl = `ALU_ADD;
                e.memWrite = (w[6:0] == `OPC_STORE);
                e.memRead = (w[6:0] == `OPC_LOAD);
                e.memToReg = (w[6:0] == `OPC_LOAD);
                e.regWrite = (w[6:0] == `OPC_LOAD);
                fmt = (w[6:0] == `OPC_LOAD) ? fmtI : fmtS;
            end
            `OPC_OP_IMM, `OPC_OP:
            begin
                e.aluOp = `AOP_ARITH;
                e.aluSrc = (w[6:0] == `OPC_OP_IMM);
                e.regWrite = 1'b1;
                e.aluControl = alu[4:0];
                e.illegal = alu[5];
                fmt = (w[6:0] == `OPC_OP_IMM) ? fmtI : fmtNone;
            end
            default:
                e.illegal = (w != '0);
        endcase
        if (e.illegal)
        begin
            e = '0;
            e.illegal = 1'b1;
            fmt = fmtNone;
        end
        e.imm = refImm(w, fmt);
        return e;
    endfunction

    always_comb want = refDecode(expInstr);

    task automatic reportMismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errorCount++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycleCount);
    endtask

    assert property (@(posedge clk) disable iff (rst) memWrite == want.memWrite)
        else reportMismatch("memWrite", 32'(memWrite), 32'(want.memWrite));
    assert property (@(posedge clk) disable iff (rst) memRead == want.memRead)
        else reportMismatch("memRead", 32'(memRead), 32'(want.memRead));
    assert property (@(posedge clk) disable iff (rst) regWrite == want.regWrite)
        else reportMismatch("regWrite", 32'(regWrite), 32'(want.regWrite));
    assert property (@(posedge clk) disable iff (rst) memToReg == want.memToReg)
        else reportMismatch("memToReg", 32'(memToReg), 32'(want.memToReg));
    assert property (@(posedge clk) disable iff (rst) aluSrc == want.aluSrc)
        else reportMismatch("aluSrc", 32'(aluSrc), 32'(want.aluSrc));
    assert property (@(posedge clk) disable iff (rst) aluOp == want.aluOp)
        else reportMismatch("aluOp", 32'(aluOp), 32'(want.aluOp));
    assert property (@(posedge clk) disable iff (rst) pcSrc == want.pcSrc)
        else reportMismatch("pcSrc", 32'(pcSrc), 32'(want.pcSrc));
    assert property (@(posedge clk) disable iff (rst) branchType == want.branchType)
        else reportMismatch("branchType", 32'(branchType), 32'(want.branchType));
    assert property (@(posedge clk) disable iff (rst) aluControl == want.aluControl)
        else reportMismatch("aluControl", 32'(aluControl), 32'(want.aluControl));
    assert property (@(posedge clk) disable iff (rst) illegal == want.illegal)
        else reportMismatch("illegal", 32'(illegal), 32'(want.illegal));
    assert property (@(posedge clk) disable iff (rst) imm == want.imm)
        else reportMismatch("imm", imm, want.imm);
    assert property (@(posedge clk) disable iff (rst) regDest == expInstr[11:7])
        else reportMismatch("regDest", 32'(regDest), 32'(expInstr[11:7]));
    assert property (@(posedge clk) disable iff (rst) pcOut == expPc)
        else reportMismatch("pcOut", pcOut, expPc);
    assert property (@(posedge clk) disable iff (rst) value1 == expValue1)
        else reportMismatch("value1", value1, expValue1);
    assert property (@(posedge clk) disable iff (rst) value2 == expValue2)
        else reportMismatch("value2", value2, expValue2);
    // Register file addresses bypass the latch
    assert property (@(posedge clk) disable iff (rst) rs1 == nextInstruction[19:15])
        else reportMismatch("rs1", 32'(rs1), 32'(nextInstruction[19:15]));
    assert property (@(posedge clk) disable iff (rst) rs2 == nextInstruction[24:20])
        else reportMismatch("rs2", 32'(rs2), 32'(nextInstruction[24:20]));
    assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(pcOut) && $stable(value1) && $stable(value2) && $stable(imm)))
        else
        begin
            errorCount++;
            $display("Outputs changed while stall was high (cycle %0d)", cycleCount);
        end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == 4000)
        begin
            $display("Timeout: the tests did not finish within 4000 cycles");
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic driveWord(input wordT w, input logic st);
        @(posedge clk);
        nextInstruction <= w;
        pc <= $urandom;
        regValue1 <= $urandom;
        regValue2 <= $urandom;
        stall <= st;
    endtask

    function automatic logic [6:0] keptOpcode(input int idx);
        case (idx)
            0:       return `OPC_LUI;
            1:       return `OPC_AUIPC;
            2:       return `OPC_JAL;
            3:       return `OPC_JALR;
            4:       return `OPC_BRANCH;
            5:       return `OPC_LOAD;
            6:       return `OPC_STORE;
            7:       return `OPC_OP_IMM;
            default: return `OPC_OP;
        endcase
    endfunction

    function automatic logic isKept(input logic [6:0] opc);
        for (int i = 0; i < 9; i++)
        begin
            if (keptOpcode(i) == opc)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic wordT withOpcode(input logic [6:0] opc);
        wordT w;
        w = $urandom;
        w[6:0] = opc;
        return w;
    endfunction

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        $display("Test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    initial
    begin
        int          startErrors;
        int          len;
        logic [31:0] r;
        wordT        w;
        void'($urandom(32'hb18a_2139));
        rst <= 1'b1;
        stall <= 1'b1;
        nextInstruction <= '0;
        pc <= '0;
        regValue1 <= '0;
        regValue2 <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        startErrors = errorCount;
        repeat (2) driveWord('0, 1'b1);
        repeat (8) driveWord('0, 1'b0);
        finishTest("reset and bubble", startErrors);

        startErrors = errorCount;
        for (int op = 0; op < 9; op++)
            repeat (50) driveWord(withOpcode(keptOpcode(op)), 1'b0);
        finishTest("kept opcodes", startErrors);

        // Every funct3 with base, alternate, M and random funct7
        startErrors = errorCount;
        for (int sel = 0; sel < 4; sel++)
        begin
            for (int f3 = 0; f3 < 8; f3++)
            begin
                repeat (12)
                begin
                    r = $urandom;
                    w = withOpcode(r[0] ? `OPC_OP : `OPC_OP_IMM);
                    w[14:12] = f3[2:0];
                    w[31:25] = (sel == 0) ? `F7_BASE : (sel == 1) ? `F7_ALT :
                               (sel == 2) ? `F7_MULDIV : r[31:25];
                    driveWord(w, 1'b0);
                end
            end
        end
        finishTest("ALU control codes", startErrors);

        startErrors = errorCount;
        repeat (300)
        begin
            r = $urandom;
            driveWord(withOpcode(keptOpcode(int'(r[7:4]) % 9)), r[0]);
        end
        finishTest("rs1 and rs2 bypass", startErrors);

        startErrors = errorCount;
        for (int n = 0; n < 20; n++)
        begin
            driveWord(withOpcode(keptOpcode(n % 9)), 1'b0);
            r = $urandom;
            len = int'(r[3:0]) + 1;
            repeat (len) driveWord(withOpcode(keptOpcode(int'(r[7:4]) % 9)), 1'b1);
        end
        finishTest("stall hold", startErrors);

        startErrors = errorCount;
        repeat (120)
        begin
            do
                w = $urandom;
            while (isKept(w[6:0]));
            driveWord(w, 1'b0);
        end
        // Atomics, FENCE and SYSTEM
        repeat (30) driveWord(withOpcode(7'b0101111), 1'b0);
        repeat (30) driveWord(withOpcode(7'b0001111), 1'b0);
        repeat (30) driveWord(withOpcode(7'b1110011), 1'b0);
        repeat (60)
        begin
            r = $urandom;
            w = withOpcode(`OPC_JALR);
            w[14:12] = (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
            driveWord(w, 1'b0);
            w = withOpcode(`OPC_BRANCH);
            w[14:12] = {2'b01, r[3]};
            driveWord(w, 1'b0);
        end
        repeat (3) driveWord('0, 1'b0);
        finishTest("illegal words", startErrors);

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: rtl/aluControlDecoder.sv
// Valid only for OP and OP-IMM words; other opcodes give a meaningless code that the caller ignores
`timescale 1ns/1ps
`include "rvDecode_defs.svh"

module aluControlDecoder
    import rvDecodePkg::*;
(
    input  wordT    instr,
    input  logic    isImm,
    output aluCtrlT aluControl,
    output logic    functIllegal
);

    funct3T     funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        // Illegal combinations leave code 0
        aluControl   = '0;
        functIllegal = 1'b0;

        if (isImm)
        begin
            case (funct3)
                3'd0: aluControl = `ALU_ADD;
                3'd2: aluControl = `ALU_SLT;
                3'd3: aluControl = `ALU_SLTU;
                3'd4: aluControl = `ALU_XOR;
                3'd6: aluControl = `ALU_OR;
                3'd7: aluControl = `ALU_AND;
                3'd1:
                begin
                    // Shift amount is in bits 24:20, upper bits must be zero
                    if (funct7 == `F7_BASE)
                        aluControl = `ALU_SLL;
                    else
                        functIllegal = 1'b1;
                end
                default:
                begin
                    if (funct7 == `F7_BASE)
                        aluControl = `ALU_SRL;
                    else if (funct7 == `F7_ALT)
                        aluControl = `ALU_SRA;
                    else
                        functIllegal = 1'b1;
                end
            endcase
        end
        else
        begin
            case (funct7)
                `F7_BASE:
                begin
                    case (funct3)
                        3'd0:    aluControl = `ALU_ADD;
                        3'd1:    aluControl = `ALU_SLL;
                        3'd2:    aluControl = `ALU_SLT;
                        3'd3:    aluControl = `ALU_SLTU;
                        3'd4:    aluControl = `ALU_XOR;
                        3'd5:    aluControl = `ALU_SRL;
                        3'd6:    aluControl = `ALU_OR;
                        default: aluControl = `ALU_AND;
                    endcase
                end
                `F7_ALT:
                begin
                    if (funct3 == 3'd0)
                        aluControl = `ALU_SUB;
                    else if (funct3 == 3'd5)
                        aluControl = `ALU_SRA;
                    else
                        functIllegal = 1'b1;
                end
                `F7_MULDIV:
                begin
                    // RV32M in funct3 order
                    case (funct3)
                        3'd0:    aluControl = `ALU_MUL;
                        3'd1:    aluControl = `ALU_MULH;
                        3'd2:    aluControl = `ALU_MULHSU;
                        3'd3:    aluControl = `ALU_MULHU;
                        3'd4:    aluControl = `ALU_DIV;
                        3'd5:    aluControl = `ALU_DIVU;
                        3'd6:    aluControl = `ALU_REM;
                        default: aluControl = `ALU_REMU;
                    endcase
                end
                default:
                    functIllegal = 1'b1;
            endcase
        end
    end

endmodule

// File: rtl/controlDecoder.sv
// RV32IM only; FENCE, SYSTEM and atomics are flagged illegal and decode with every control inactive
`timescale 1ns/1ps
`include "rvDecode_defs.svh"

module controlDecoder
    import rvDecodePkg::*;
(
    input  wordT    instr,
    output logic    memWrite,
    output logic    memRead,
    output logic    regWrite,
    output logic    memToReg,
    output logic    aluSrc,
    output aluOpT   aluOp,
    output logic    pcSrc,
    output funct3T  branchType,
    output aluCtrlT aluControl,
    output immFmtT  immFmt,
    output logic    illegal
);

    logic [6:0] opcode;
    funct3T     funct3;
    logic       isImm;
    logic       isBubble;
    aluCtrlT    functCode;
    logic       functIllegal;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign isImm    = (opcode == `OPC_OP_IMM);
    assign isBubble = (instr == '0);

    aluControlDecoder u_aluControlDecoder (
        .instr        (instr),
        .isImm        (isImm),
        .aluControl   (functCode),
        .functIllegal (functIllegal)
    );

    // Opcode and funct3 legality
    always_comb
    begin
        case (opcode)
            `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_LOAD, `OPC_STORE:
                illegal = 1'b0;
            `OPC_JALR:
                illegal = (funct3 != 3'd0);
            `OPC_BRANCH:
                illegal = (funct3 == 3'd2) || (funct3 == 3'd3);
            `OPC_OP_IMM, `OPC_OP:
                illegal = functIllegal;
            default:
                illegal = !isBubble;
        endcase
    end

    // Main controls, all inactive unless the word is legal
    always_comb
    begin
        memWrite   = 1'b0;
        memRead    = 1'b0;
        regWrite   = 1'b0;
        memToReg   = 1'b0;
        aluSrc     = 1'b0;
        aluOp      = `AOP_MEM;
        pcSrc      = 1'b0;
        branchType = 3'd0;
        aluControl = '0;
        immFmt     = fmtNone;

        if (!illegal)
        begin
            case (opcode)
                `OPC_LUI, `OPC_AUIPC:
                begin
                    aluOp      = (opcode == `OPC_LUI) ? `AOP_LUI : `AOP_AUIPC;
                    aluSrc     = 1'b1;
                    regWrite   = 1'b1;
                    aluControl = `ALU_ADD;
                    immFmt     = fmtU;
                end
                `OPC_JAL, `OPC_JALR:
                begin
                    // Link address goes to rd, target goes to fetch
                    aluOp      = (opcode == `OPC_JAL) ? `AOP_JAL : `AOP_JALR;
                    regWrite   = 1'b1;
                    pcSrc      = 1'b1;
                    aluControl = `ALU_ADD;
                    immFmt     = (opcode == `OPC_JAL) ? fmtJ : fmtI;
                end
                `OPC_BRANCH:
                begin
                    // Compare by subtraction in execute
                    aluOp      = `AOP_BRANCH;
                    pcSrc      = 1'b1;
                    aluControl = `ALU_SUB;
                    immFmt     = fmtB;
                    branchType = funct3;
                end
                `OPC_LOAD:
                begin
                    aluSrc     = 1'b1;
                    regWrite   = 1'b1;
                    memRead    = 1'b1;
                    memToReg   = 1'b1;
                    aluControl = `ALU_ADD;
                    immFmt     = fmtI;
                end
                `OPC_STORE:
                begin
                    aluSrc     = 1'b1;
                    memWrite   = 1'b1;
                    aluControl = `ALU_ADD;
                    immFmt     = fmtS;
                end
                `OPC_OP_IMM, `OPC_OP:
                begin
                    aluOp      = `AOP_ARITH;
                    aluSrc     = isImm;
                    regWrite   = 1'b1;
                    aluControl = functCode;
                    immFmt     = isImm ? fmtI : fmtNone;
                end
                default:
                begin
                    // Bubble keeps the defaults
                    immFmt = fmtNone;
                end
            endcase
        end
    end

endmodule

// File: rtl/decodeLatch.sv
// Holds its contents while stall is high; reset loads the all-zero word, which decodes as a bubble
`timescale 1ns/1ps

module decodeLatch
    import rvDecodePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic stall,

    // Fetch side and register file read data
    input  wordT nextInstruction,
    input  wordT pc,
    input  wordT regValue1,
    input  wordT regValue2,

    // Captured values
    output wordT instr,
    output wordT pcOut,
    output wordT value1,
    output wordT value2
);

    // Only state in the stage
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instr  <= '0;
            pcOut  <= '0;
            value1 <= '0;
            value2 <= '0;
        end
        else if (!stall)
        begin
            instr  <= nextInstruction;
            pcOut  <= pc;
            value1 <= regValue1;
            value2 <= regValue2;
        end
    end

endmodule

// File: rtl/decodeStage.sv
// One-cycle decode; rs1 and rs2 come from the incoming word so the register file read lines up
`timescale 1ns/1ps

module decodeStage
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  rvDecodePkg::wordT    nextInstruction,
    input  rvDecodePkg::wordT    pc,
    input  rvDecodePkg::wordT    regValue1,
    input  rvDecodePkg::wordT    regValue2,

    // Register file read addresses, zero cycles from nextInstruction
    output rvDecodePkg::regAddrT rs1,
    output rvDecodePkg::regAddrT rs2,
    output rvDecodePkg::regAddrT regDest,

    output rvDecodePkg::wordT    imm,
    output rvDecodePkg::wordT    pcOut,
    output rvDecodePkg::wordT    value1,
    output rvDecodePkg::wordT    value2,

    // Controls for execute, memory and writeback
    output logic                 memWrite,
    output logic                 memRead,
    output logic                 regWrite,
    output logic                 memToReg,
    output logic                 aluSrc,
    output rvDecodePkg::aluOpT   aluOp,
    output logic                 pcSrc,
    output rvDecodePkg::funct3T  branchType,
    output rvDecodePkg::aluCtrlT aluControl,
    output logic                 illegal
);

    rvDecodePkg::wordT   instr;
    rvDecodePkg::immFmtT immFmt;

    assign rs1     = nextInstruction[19:15];
    assign rs2     = nextInstruction[24:20];
    assign regDest = instr[11:7];

    decodeLatch u_decodeLatch (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .nextInstruction (nextInstruction),
        .pc              (pc),
        .regValue1       (regValue1),
        .regValue2       (regValue2),
        .instr           (instr),
        .pcOut           (pcOut),
        .value1          (value1),
        .value2          (value2)
    );

    controlDecoder u_controlDecoder (
        .instr      (instr),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .regWrite   (regWrite),
        .memToReg   (memToReg),
        .aluSrc     (aluSrc),
        .aluOp      (aluOp),
        .pcSrc      (pcSrc),
        .branchType (branchType),
        .aluControl (aluControl),
        .immFmt     (immFmt),
        .illegal    (illegal)
    );

    immGen u_immGen (
        .instr  (instr),
        .immFmt (immFmt),
        .imm    (imm)
    );

endmodule

// File: rtl/immGen.sv
// Base ISA immediate layouts only; every format is sign-extended from instruction bit 31
`timescale 1ns/1ps

module immGen
    import rvDecodePkg::*;
(
    input  wordT   instr,
    input  immFmtT immFmt,
    output wordT   imm
);

    logic sign;

    assign sign = instr[31];

    always_comb
    begin
        case (immFmt)
            fmtI:
                imm = {{20{sign}}, instr[31:20]};
            fmtS:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are halfword aligned
            fmtB:
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            fmtU:
                imm = {instr[31:12], 12'b0};
            fmtJ:
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: rtl/rvDecodePkg.sv
// Types for a single-lane RV32IM decode stage; widths come from rvDecode_defs.svh
`include "rvDecode_defs.svh"

package rvDecodePkg;

    // Data, instruction and PC word
    typedef logic [`XLEN-1:0] wordT;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // Code that selects the ALU function in execute
    typedef logic [4:0] aluCtrlT;

    // Coarse operation class for execute
    typedef logic [2:0] aluOpT;

    // Instruction funct3 field, also used as branch condition
    typedef logic [2:0] funct3T;

    // Immediate layouts of the base ISA
    // fmtNone gives a zero immediate (R-type, bubble, illegal)
    typedef enum logic [2:0]
    {
        fmtNone,
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ
    } immFmtT;

endpackage

// File: rtl/rvDecode_defs.svh
// RV32I and RV32M encodings only; ALU codes must match the execute stage numbering
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// Widths
`define XLEN       32
`define REG_ADDR_W 5

// Major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

// Funct7 groups
`define F7_BASE   7'b0000000
`define F7_ALT    7'b0100000
`define F7_MULDIV 7'b0000001

// ALU control codes as seen by execute
`define ALU_AND    5'd0
`define ALU_OR     5'd1
`define ALU_ADD    5'd2
`define ALU_XOR    5'd3
`define ALU_SUB    5'd4
`define ALU_SLL    5'd6
`define ALU_SRL    5'd7
`define ALU_SRA    5'd8
`define ALU_SLT    5'd9
`define ALU_SLTU   5'd10
`define ALU_MUL    5'd11
`define ALU_MULH   5'd12
`define ALU_MULHSU 5'd13
`define ALU_MULHU  5'd14
`define ALU_DIV    5'd15
`define ALU_DIVU   5'd16
`define ALU_REM    5'd17
`define ALU_REMU   5'd18

// ALU operation classes
`define AOP_MEM    3'd0
`define AOP_BRANCH 3'd1
`define AOP_ARITH  3'd2
`define AOP_JAL    3'd3
`define AOP_LUI    3'd4
`define AOP_AUIPC  3'd5
`define AOP_JALR   3'd7

`endif

// File: run.sh
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module decodeStageTb -o decodeStageSim
./obj_dir/decodeStageSim > sim.log
cat sim.log
grep -q "Testbench passed" sim.log

// File: src.f
+incdir+rtl
rtl/rvDecodePkg.sv
rtl/decodeLatch.sv
rtl/aluControlDecoder.sv
rtl/controlDecoder.sv
rtl/immGen.sv
rtl/decodeStage.sv
bench/decodeStageTb.sv
